// File: logic/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width, one RV32 word
`define CORE_XLEN 32

// register number width, x0 to x31
`define CORE_REG_AW 5

// architectural registers including x0
`define CORE_NUM_REGS 32

`endif

// File: logic/core_pkg.sv
`default_nettype none

`include "core_params.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;
    typedef logic [31:0] inst_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_LUI   = 7'b0110111,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B // lui passes the upper immediate
    } alu_op_t;

    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        logic      is_load;
        logic      is_store;
        logic      writes_rd; // never set for rd equal to x0
        reg_addr_t rd;
        word_t     op_a;
        word_t     op_b;
        word_t     st_data;
    } dec_exe_t;

    typedef struct packed {
        logic      valid;
        logic      writes_rd;
        reg_addr_t rd;
        word_t     value;
    } exe_res_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      uses_rs1;
        logic      uses_rs2;
    } src_use_t;

    typedef enum logic {
        BUS_IDLE,
        BUS_ACCESS
    } bus_state_t;

endpackage

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module reg_file import core_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire reg_addr_t raddr1,
    input  wire reg_addr_t raddr2,
    output word_t          rdata1,
    output word_t          rdata2,
    input  wire logic      we,
    input  wire reg_addr_t waddr,
    input  wire word_t     wdata
);

    word_t regs [`CORE_NUM_REGS-1:1]; // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // the write port value is visible in the same cycle
    assign rdata1 = (raddr1 == '0) ? '0 : (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : (we && waddr == raddr2) ? wdata : regs[raddr2];

    // decode clears writes_rd for x0, so no write to x0 reaches this port
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n) we |-> waddr != '0);

endmodule

`default_nettype wire

// File: logic/hazard_detect.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detect import core_pkg::*; (
    input  wire src_use_t  src,
    input  wire logic      exe_valid,
    input  wire logic      exe_writes_rd,
    input  wire reg_addr_t exe_rd,
    output logic           stall
);

    logic exe_dest; // execute holds a pending register write
    logic hit_rs1;
    logic hit_rs2;

    assign exe_dest = exe_valid && exe_writes_rd && exe_rd != '0;

    // only sources that decode really reads can cause a hold
    assign hit_rs1 = src.uses_rs1 && src.rs1 == exe_rd;
    assign hit_rs2 = src.uses_rs2 && src.rs2 == exe_rd;

    // no forwarding path exists, so the front end waits
    assign stall = exe_dest && (hit_rs1 || hit_rs2);

endmodule

`default_nettype wire

// File: logic/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  inst_valid,
    input  wire inst_t inst_data,
    output logic       inst_ready,
    input  wire logic  stall,
    input  wire logic  exe_ready,
    output src_use_t   src,
    output reg_addr_t  raddr1,
    output reg_addr_t  raddr2,
    input  wire word_t rdata1,
    input  wire word_t rdata2,
    output dec_exe_t   dec_out
);

    opcode_t   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd_f;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_u;
    logic      known_op;
    logic      run_q; // low during reset and its first cycle out
    logic      take;
    dec_exe_t  dec_d;
    dec_exe_t  dec_q;

    assign opcode = opcode_t'(inst_data[6:0]);
    assign rd_f   = inst_data[11:7];
    assign funct3 = inst_data[14:12];
    assign funct7 = inst_data[31:25];
    assign raddr1 = inst_data[19:15];
    assign raddr2 = inst_data[24:20];

    assign imm_i = {{20{inst_data[31]}}, inst_data[31:20]};
    assign imm_s = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
    assign imm_u = {inst_data[31:12], 12'b0};

    always_comb begin
        dec_d          = '0;
        src            = '0;
        known_op       = 1'b1;
        src.rs1        = raddr1;
        src.rs2        = raddr2;
        dec_d.valid    = 1'b1;
        dec_d.rd       = rd_f;
        dec_d.alu_op   = ALU_ADD;
        dec_d.op_a     = rdata1;
        dec_d.op_b     = rdata2;
        dec_d.st_data  = rdata2;
        case (opcode)
            OP_REG: begin
                src.uses_rs1    = 1'b1;
                src.uses_rs2    = 1'b1;
                dec_d.writes_rd = 1'b1;
                case (funct3)
                    3'b000:  dec_d.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b100:  dec_d.alu_op = ALU_XOR;
                    3'b110:  dec_d.alu_op = ALU_OR;
                    3'b111:  dec_d.alu_op = ALU_AND;
                    default: known_op = 1'b0;
                endcase
            end
            OP_IMM: begin
                src.uses_rs1    = 1'b1;
                dec_d.writes_rd = 1'b1;
                dec_d.op_b      = imm_i;
                known_op        = funct3 == 3'b000; // addi only
            end
            OP_LUI: begin
                dec_d.writes_rd = 1'b1;
                dec_d.alu_op    = ALU_PASS_B;
                dec_d.op_b      = imm_u;
            end
            OP_LOAD: begin
                src.uses_rs1    = 1'b1;
                dec_d.is_load   = 1'b1;
                dec_d.writes_rd = 1'b1;
                dec_d.op_b      = imm_i;
                known_op        = funct3 == 3'b010;
            end
            OP_STORE: begin
                src.uses_rs1   = 1'b1;
                src.uses_rs2   = 1'b1;
                dec_d.is_store = 1'b1;
                dec_d.op_b     = imm_s;
                known_op       = funct3 == 3'b010;
            end
            default: known_op = 1'b0;
        endcase
        dec_d.writes_rd = dec_d.writes_rd && rd_f != '0;
    end

    assign inst_ready = run_q && exe_ready && !stall;
    assign take       = inst_valid && inst_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            dec_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (exe_ready) begin
                dec_q <= take ? dec_d : '0; // a held instruction leaves a bubble behind
            end
        end
    end

    assign dec_out = dec_q;

    a_known_op: assert property (@(posedge clk) disable iff (!rst_n) take |-> known_op);

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire dec_exe_t dec_in,
    output logic          exe_ready,
    output logic          exe_valid,
    output logic          exe_writes_rd,
    output reg_addr_t     exe_rd,
    output exe_res_t      res_out,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output word_t         wb_adr,
    output word_t         wb_dat_o,
    output logic [3:0]    wb_sel,
    input  wire word_t    wb_dat_i,
    input  wire logic     wb_ack
);

    bus_state_t state_q;
    bus_state_t state_d;
    logic       mem_op;
    logic       bus_done;
    word_t      alu_res;

    assign mem_op   = dec_in.valid && (dec_in.is_load || dec_in.is_store);
    assign bus_done = state_q == BUS_ACCESS && wb_ack;

    always_comb begin
        case (dec_in.alu_op)
            ALU_ADD:    alu_res = dec_in.op_a + dec_in.op_b;
            ALU_SUB:    alu_res = dec_in.op_a - dec_in.op_b;
            ALU_AND:    alu_res = dec_in.op_a & dec_in.op_b;
            ALU_OR:     alu_res = dec_in.op_a | dec_in.op_b;
            ALU_XOR:    alu_res = dec_in.op_a ^ dec_in.op_b;
            ALU_PASS_B: alu_res = dec_in.op_b;
            default:    alu_res = '0;
        endcase
    end

    // the cycle is opened one clock after the memory instruction arrives
    always_comb begin
        state_d = state_q;
        case (state_q)
            BUS_IDLE:   if (mem_op) state_d = BUS_ACCESS;
            BUS_ACCESS: if (wb_ack) state_d = BUS_IDLE;
            default:    state_d = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= BUS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign wb_cyc   = state_q == BUS_ACCESS;
    assign wb_stb   = state_q == BUS_ACCESS;
    assign wb_we    = state_q == BUS_ACCESS && dec_in.is_store;
    assign wb_adr   = alu_res; // decode sets up add with the offset
    assign wb_dat_o = dec_in.st_data;
    assign wb_sel   = 4'hf;

    assign exe_ready     = !mem_op || bus_done;
    assign exe_valid     = dec_in.valid;
    assign exe_writes_rd = dec_in.writes_rd;
    assign exe_rd        = dec_in.rd;

    // stores finish on the bus and hand a bubble to the result stage
    assign res_out.valid     = dec_in.valid && !dec_in.is_store && (!dec_in.is_load || bus_done);
    assign res_out.writes_rd = dec_in.writes_rd;
    assign res_out.rd        = dec_in.rd;
    assign res_out.value     = dec_in.is_load ? wb_dat_i : alu_res;

    // decode must keep the instruction steady while the bus waits
    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_we));

endmodule

`default_nettype wire

// File: logic/result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module result_stage import core_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire exe_res_t res_in,
    output logic          we,
    output reg_addr_t     waddr,
    output word_t         wdata,
    output logic          ret_valid,
    output reg_addr_t     ret_rd,
    output word_t         ret_value
);

    exe_res_t res_q;
    logic     wr_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_q <= '0;
        end else begin
            res_q <= res_in; // never back-pressured
        end
    end

    assign wr_en = res_q.valid && res_q.writes_rd;

    assign we    = wr_en;
    assign waddr = res_q.rd;
    assign wdata = res_q.value;

    // retire mirrors the register file write
    assign ret_valid = wr_en;
    assign ret_rd    = res_q.rd;
    assign ret_value = res_q.value;

endmodule

`default_nettype wire

// File: logic/pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_top import core_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  inst_valid,
    input  wire inst_t inst_data,
    output logic       inst_ready,
    output logic       wb_cyc,
    output logic       wb_stb,
    output logic       wb_we,
    output word_t      wb_adr,
    output word_t      wb_dat_o,
    output logic [3:0] wb_sel,
    input  wire word_t wb_dat_i,
    input  wire logic  wb_ack,
    output logic       ret_valid,
    output reg_addr_t  ret_rd,
    output word_t      ret_value
);

    src_use_t  src;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;
    logic      stall;
    logic      exe_ready;
    logic      exe_valid;
    logic      exe_writes_rd;
    reg_addr_t exe_rd;
    dec_exe_t  dec_exe;
    exe_res_t  exe_res;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    reg_file i_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    hazard_detect i_hazard_detect (
        .src           (src),
        .exe_valid     (exe_valid),
        .exe_writes_rd (exe_writes_rd),
        .exe_rd        (exe_rd),
        .stall         (stall)
    );

    inst_decode i_inst_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .inst_ready (inst_ready),
        .stall      (stall),
        .exe_ready  (exe_ready),
        .src        (src),
        .raddr1     (raddr1),
        .raddr2     (raddr2),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .dec_out    (dec_exe)
    );

    execute_unit i_execute_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_in        (dec_exe),
        .exe_ready     (exe_ready),
        .exe_valid     (exe_valid),
        .exe_writes_rd (exe_writes_rd),
        .exe_rd        (exe_rd),
        .res_out       (exe_res),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_o      (wb_dat_o),
        .wb_sel        (wb_sel),
        .wb_dat_i      (wb_dat_i),
        .wb_ack        (wb_ack)
    );

    result_stage i_result_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_in    (exe_res),
        .we        (rf_we),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata),
        .ret_valid (ret_valid),
        .ret_rd    (ret_rd),
        .ret_value (ret_value)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 5; // 10 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // released away from the sampling edge
    end

endmodule

`default_nettype wire

// File: bench/tb_pipe_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_top import core_pkg::*;;

    localparam int RESET_CYCLES = 10;
    localparam int MEM_WORDS = 64;
    localparam int GOLDEN_WORDS = 256;
    localparam int unsigned SEED = 32'h9534_de18;

    logic       clk;
    logic       rst_n;
    logic       inst_valid;
    inst_t      inst_data;
    logic       inst_ready;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_dat_o;
    logic [3:0] wb_sel;
    word_t      wb_dat_i;
    logic       wb_ack;
    logic       ret_valid;
    reg_addr_t  ret_rd;
    word_t      ret_value;

    word_t     golden [0:GOLDEN_WORDS-1];
    word_t     mem [0:MEM_WORDS-1];
    inst_t     inst_q [$];
    reg_addr_t ret_rd_q [$];
    word_t     ret_val_q [$];
    word_t     st_adr_q [$];
    word_t     st_dat_q [$];

    int          cycle_count;
    int          timeout_limit;
    int unsigned gap;
    int unsigned mem_wait;
    inst_t       next_inst;
    reg_addr_t   prev_rd;
    word_t       req_adr;
    word_t       req_dat;
    logic        req_we;

    tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pipe_top i_pipe_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .inst_ready (inst_ready),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_sel     (wb_sel),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack),
        .ret_valid  (ret_valid),
        .ret_rd     (ret_rd),
        .ret_value  (ret_value)
    );

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run();
        end
    endtask

    function automatic int mem_index(input word_t adr);
        return adr[7:2];
    endfunction

    // field match only, so an immediate that looks like a source just drops the gap
    function automatic logic reads_reg(input inst_t word, input reg_addr_t rd);
        return rd != '0 && (word[19:15] == rd || word[24:20] == rd);
    endfunction

    // records are four words each: tag, instruction or address, then two payload words
    task automatic load_golden();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc0de_0000 | (i * 4); // unset words carry their own byte address
        end
        for (i = 0; i < GOLDEN_WORDS; i++) begin
            golden[i] = '0;
        end
        $readmemh("bench/pipe_golden.txt", golden);
        i = 0;
        while (i + 3 < GOLDEN_WORDS && golden[i] != '0) begin
            case (golden[i])
                32'd1: begin
                    inst_q.push_back(golden[i+1]);
                    if (golden[i+2] != '0) begin // rd of zero retires nothing
                        ret_rd_q.push_back(golden[i+2][4:0]);
                        ret_val_q.push_back(golden[i+3]);
                    end
                end
                32'd2: begin
                    inst_q.push_back(golden[i+1]);
                    st_adr_q.push_back(golden[i+2]);
                    st_dat_q.push_back(golden[i+3]);
                end
                32'd3: mem[mem_index(golden[i+1])] = golden[i+2];
                default: begin
                    $display("golden file holds an unknown record tag %0h", golden[i]);
                    stop_run();
                end
            endcase
            i += 4;
        end
    endtask

    task automatic send_inst(input inst_t word);
        inst_valid = 1'b1;
        inst_data  = word;
        #1; // let ready settle after the falling edge
        while (!inst_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    initial begin
        inst_valid  = 1'b0;
        inst_data   = '0;
        wb_ack      = 1'b0;
        wb_dat_i    = '0;
        cycle_count = 0;
        prev_rd     = '0;
        void'($urandom(SEED));
        load_golden();
        timeout_limit = 8 * inst_q.size() + RESET_CYCLES;
        @(posedge rst_n);
        @(negedge clk);
        while (inst_q.size() != 0) begin
            next_inst = inst_q.pop_front();
            gap = $urandom_range(2, 0);
            if (reads_reg(next_inst, prev_rd)) begin
                gap = 0; // dependent pairs go back to back so decode has to hold
            end
            repeat (gap) @(negedge clk);
            send_inst(next_inst);
            prev_rd = next_inst[11:7];
        end
        while (ret_rd_q.size() != 0 || st_adr_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // a stray retire or store still shows up here
        $display("*** PASSED ***");
        $finish;
    end

    // Wishbone slave with a random wait before each ack
    always begin
        @(negedge clk);
        if (rst_n && wb_cyc) begin
            req_adr = wb_adr;
            req_dat = wb_dat_o;
            req_we  = wb_we;
            check_value("wb_stb", wb_stb, 1);
            check_value("wb_sel", wb_sel, 4'hf);
            if (req_adr[1:0] != 2'b00 || req_adr >= MEM_WORDS * 4) begin
                $display("bus access at 0x%08h lies outside the memory model", req_adr);
                stop_run();
            end
            mem_wait = $urandom_range(3, 0);
            repeat (mem_wait) begin
                @(negedge clk);
                check_value("wb_cyc", wb_cyc, 1); // request holds until ack
                check_value("wb_stb", wb_stb, 1);
                check_value("wb_adr", wb_adr, req_adr);
                check_value("wb_we", wb_we, req_we);
                if (req_we) begin
                    check_value("wb_dat_o", wb_dat_o, req_dat);
                end
            end
            if (req_we) begin
                if (st_adr_q.size() == 0) begin
                    $display("store to 0x%08h arrived with no store record left", req_adr);
                    stop_run();
                end
                check_value("wb_adr", req_adr, st_adr_q.pop_front());
                check_value("wb_dat_o", req_dat, st_dat_q.pop_front());
                mem[mem_index(req_adr)] = req_dat;
            end else begin
                wb_dat_i = mem[mem_index(req_adr)];
            end
            wb_ack = 1'b1;
            @(negedge clk);
            wb_ack = 1'b0;
            check_value("wb_cyc", wb_cyc, 0); // the cycle closes right after ack
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("inst_ready", inst_ready, 0);
            check_value("wb_cyc", wb_cyc, 0);
            check_value("ret_valid", ret_valid, 0);
        end else if (ret_valid) begin
            if (ret_rd_q.size() == 0) begin
                $display("retire of x%0d arrived with no retire record left", ret_rd);
                stop_run();
            end
            check_value("ret_rd", ret_rd, ret_rd_q.pop_front());
            check_value("ret_value", ret_value, ret_val_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout after %0d cycles with %0d retire and %0d store records open",
                cycle_count, ret_rd_q.size(), st_adr_q.size());
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/core_pkg.sv
logic/reg_file.sv
logic/hazard_detect.sv
logic/inst_decode.sv
logic/execute_unit.sv
logic/result_stage.sv
logic/pipe_top.sv
bench/tb_clock_gen.sv
bench/tb_pipe_top.sv

// File: bench/pipe_golden.txt
// columns: tag, word, a, b; tag 1 is an instruction with expected rd and value (rd 0 retires nothing)
// tag 2 is a store with expected bus address and data, tag 3 presets memory address a with b
3 00000010 12345678 00000000
3 00000014 000000ff 00000000
1 00500093 00000001 00000005
1 00c00113 00000002 0000000c
1 abcde1b7 00000003 abcde000
1 00208233 00000004 00000011
1 401182b3 00000005 abcddffb
1 0020c333 00000006 00000009
1 0020e3b3 00000007 0000000d
1 0022f433 00000008 00000008
1 00140493 00000009 00000009
1 00948533 0000000a 00000012
1 401505b3 0000000b 0000000d
1 01002603 0000000c 12345678
1 001606b3 0000000d 1234567d
2 02d02023 00000020 1234567d
1 02002703 0000000e 1234567d
1 fff70793 0000000f 1234567c
2 00f12223 00000010 1234567c
1 01402803 00000010 000000ff
1 00412883 00000011 1234567c
1 00708013 00000000 00000000
1 01000933 00000012 000000ff
1 01002003 00000000 00000000
1 011049b3 00000013 1234567c
0 00000000 00000000 00000000
